//--- bench/pe_asserts.sv
`timescale 1ns/1ns

module pe_asserts
    import pe_cfg_pkg::*;
    import pe_ctl_pkg::*;
(
    input logic                       i_clk,
    input logic                       i_rstn,
    input pe_state_e                  i_state,
    input logic                       i_input_ack,
    input logic                       i_weight_ack,
    input logic                       i_psum_rdy,
    input logic                       i_psum_ack,
    input logic [PE_ROW*PSUM_DWD-1:0] i_psum_flat
);

    // rdy holds with the same data until the receiver acks
    psum_hold: assert property (@(posedge i_clk) disable iff (!i_rstn)
        i_psum_rdy && !i_psum_ack |=> i_psum_rdy && $stable(i_psum_flat))
        else $error("o_psum_rdy dropped or o_psum changed before ack");

    input_in_run: assert property (@(posedge i_clk) disable iff (!i_rstn)
        i_input_ack |-> i_state == ST_RUN)
        else $error("input acked outside ST_RUN");

    weight_in_load: assert property (@(posedge i_clk) disable iff (!i_rstn)
        i_weight_ack |-> i_state == ST_LOAD_W)
        else $error("weight acked outside ST_LOAD_W");

endmodule

// controller state and both channels seen from the PE top level
bind pe pe_asserts u_pe_asserts (
    .i_clk        (i_clk),
    .i_rstn       (i_rstn),
    .i_state      (u_ctrl.state),
    .i_input_ack  (o_input_ack),
    .i_weight_ack (o_weight_ack),
    .i_psum_rdy   (o_psum_rdy),
    .i_psum_ack   (i_psum_ack),
    .i_psum_flat  ({o_psum[3], o_psum[2], o_psum[1], o_psum[0]})
);

//--- bench/pe_tb.sv
`timescale 1ns/1ns

module pe_tb
    import pe_cfg_pkg::*;
    import pe_ctl_pkg::*;
();

    localparam int CLK_PERIOD = 8;
    localparam int DRV_DELAY  = 1;
    localparam int TIMEOUT    = 200;

    logic     clk;
    logic     rstn;
    pe_inst_e inst;
    logic     inst_valid;
    tap_cnt_t taps;
    logic     input_rdy;
    logic     input_ack;
    data_t    input_data;
    logic     weight_rdy;
    logic     weight_ack;
    data_t    weight [PE_ROW];
    logic     psum_rdy;
    logic     psum_ack;
    psum_t    psum [PE_ROW];
    logic     idle;

    // reference model state
    logic [15:0] lfsr;
    data_t       wgt_model [PE_ROW][IPAD_N];
    data_t       window_q [$];
    psum_t       exp_q [$];
    int          cur_taps;
    int          inputs_sent;
    int          value_errors;
    int          proto_errors;
    int          timeouts;

    pe pe_i (
        .i_clk        (clk),
        .i_rstn       (rstn),
        .i_inst       (inst),
        .i_inst_valid (inst_valid),
        .i_taps       (taps),
        .i_input_rdy  (input_rdy),
        .o_input_ack  (input_ack),
        .i_input      (input_data),
        .i_weight_rdy (weight_rdy),
        .o_weight_ack (weight_ack),
        .i_weight     (weight),
        .o_psum_rdy   (psum_rdy),
        .i_psum_ack   (psum_ack),
        .o_psum       (psum),
        .o_idle       (idle)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // ============================================================
    // random numbers, 16-bit Galois LFSR
    // ============================================================

    function automatic logic [15:0] lfsr_step(logic [15:0] s);
        logic [15:0] n;
        n = s >> 1;
        if (s[0]) begin
            n = n ^ 16'hB400;
        end
        return n;
    endfunction

    // one step per bit taken
    function automatic int rand_bits(int n);
        int v;
        v = 0;
        for (int i = 0; i < n; i++) begin
            v = (v << 1) | int'(lfsr[0]);
            lfsr = lfsr_step(lfsr);
        end
        return v;
    endfunction

    // ============================================================
    // checks and end of run
    // ============================================================

    task automatic check_value(string name, longint exp, longint got);
        assert (exp == got) else begin
            value_errors++;
            $display("** Error at %0t: %s expected %0d got %0d", $time, name, exp, got);
        end
    endtask

    task automatic finish_run();
        $display("value errors: %0d, protocol errors: %0d, timeouts: %0d",
                 value_errors, proto_errors, timeouts);
        if (value_errors + proto_errors + timeouts == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    endtask

    task automatic timed_out(string what);
        timeouts++;
        $display("timeout at %0t while waiting for %s", $time, what);
        finish_run();
    endtask

    // ============================================================
    // reference model
    // ============================================================

    // slot k of the window is the sample from k inputs ago
    function automatic void model_push(data_t x);
        longint acc;
        window_q.push_front(x);
        if (window_q.size() > IPAD_N) begin
            void'(window_q.pop_back());
        end
        if (window_q.size() >= cur_taps) begin
            for (int r = 0; r < PE_ROW; r++) begin
                acc = 0;
                for (int k = 0; k < cur_taps; k++) begin
                    acc += longint'(window_q[k]) * longint'(wgt_model[r][k]);
                end
                exp_q.push_back(psum_t'(acc));
            end
        end
    endfunction

    // ============================================================
    // channel drivers
    // ============================================================

    task automatic step_cycle();
        @(posedge clk);
        #DRV_DELAY;
    endtask

    task automatic wait_idle();
        int n;
        n = 0;
        @(negedge clk);
        while (!idle) begin
            n++;
            if (n > TIMEOUT) begin
                timed_out("o_idle");
            end
            @(negedge clk);
        end
    endtask

    task automatic send_inst(pe_inst_e code, tap_cnt_t t);
        step_cycle();
        inst       = code;
        taps       = t;
        inst_valid = 1'b1;
        step_cycle();
        inst_valid = 1'b0;
        inst       = INST_NOP;
    endtask

    task automatic load_weights(int t);
        int n;
        send_inst(INST_LOAD_W, tap_cnt_t'(t));
        cur_taps = t;
        for (int k = 0; k < t; k++) begin
            weight_rdy = 1'b0;
            repeat (rand_bits(2)) step_cycle();
            for (int r = 0; r < PE_ROW; r++) begin
                weight[r]       = data_t'(rand_bits(8));
                wgt_model[r][k] = weight[r];
            end
            weight_rdy = 1'b1;
            n = 0;
            @(negedge clk);
            while (!weight_ack) begin
                n++;
                if (n > TIMEOUT) begin
                    timed_out("o_weight_ack");
                end
                @(negedge clk);
            end
            // transfer edge
            step_cycle();
        end
        weight_rdy = 1'b0;
        wait_idle();
    endtask

    task automatic send_inputs(int count);
        int n;
        for (int i = 0; i < count; i++) begin
            input_rdy = 1'b0;
            repeat (rand_bits(2)) step_cycle();
            input_data = data_t'(rand_bits(8));
            input_rdy  = 1'b1;
            n = 0;
            @(negedge clk);
            while (!input_ack) begin
                n++;
                if (n > TIMEOUT) begin
                    timed_out("o_input_ack");
                end
                @(negedge clk);
            end
            model_push(input_data);
            inputs_sent++;
            step_cycle();
        end
        input_rdy = 1'b0;
    endtask

    // random ack delay on every psum set
    task automatic collect_psums(int count);
        int n;
        for (int i = 0; i < count; i++) begin
            n = 0;
            @(negedge clk);
            while (!psum_rdy) begin
                n++;
                if (n > TIMEOUT) begin
                    timed_out("o_psum_rdy");
                end
                @(negedge clk);
            end
            repeat (rand_bits(2)) @(posedge clk);
            step_cycle();
            psum_ack = 1'b1;
            @(negedge clk);
            assert (i + 1 <= inputs_sent - cur_taps + 1) else begin
                proto_errors++;
                $display("psum set %0d came before its window was full at %0t", i, $time);
            end
            assert (exp_q.size() >= PE_ROW) else begin
                proto_errors++;
                $display("psum set arrived with no expected set left at %0t", $time);
            end
            if (exp_q.size() >= PE_ROW) begin
                for (int r = 0; r < PE_ROW; r++) begin
                    check_value($sformatf("o_psum[%0d]", r), exp_q.pop_front(), psum[r]);
                end
            end
            step_cycle();
            psum_ack = 1'b0;
        end
    endtask

    task automatic do_run(int count);
        int n_sets;
        window_q.delete();
        exp_q.delete();
        inputs_sent = 0;
        n_sets = (count >= cur_taps) ? count - cur_taps + 1 : 0;
        send_inst(INST_RUN, '0);
        fork
            send_inputs(count);
            collect_psums(n_sets);
        join
        // quiet period, no further psum may appear
        repeat (2 * IPAD_N + 4) step_cycle();
        assert (!psum_rdy && exp_q.size() == 0) else begin
            proto_errors++;
            $display("extra or missing psum sets at end of run at %0t", $time);
        end
        send_inst(INST_STOP, '0);
        wait_idle();
    endtask

    // ============================================================
    // test sequence
    // ============================================================

    initial begin
        int t1;
        int t2;
        lfsr         = 16'd14127;
        value_errors = 0;
        proto_errors = 0;
        timeouts     = 0;
        cur_taps     = 1;
        inputs_sent  = 0;
        rstn         = 1'b0;
        inst         = INST_NOP;
        inst_valid   = 1'b0;
        taps         = '0;
        input_rdy    = 1'b0;
        input_data   = '0;
        weight_rdy   = 1'b0;
        psum_ack     = 1'b0;
        for (int r = 0; r < PE_ROW; r++) begin
            weight[r] = '0;
        end
        repeat (2) @(posedge clk);
        #DRV_DELAY;
        rstn = 1'b1;

        @(negedge clk);
        check_value("o_input_ack", 0, input_ack);
        check_value("o_weight_ack", 0, weight_ack);
        check_value("o_psum_rdy", 0, psum_rdy);
        check_value("o_idle", 1, idle);

        t1 = 1 + rand_bits(2);
        load_weights(t1);
        do_run(30);
        // short run, checks the fill count
        do_run(t1 + 2);

        t2 = 1 + rand_bits(2);
        if (t2 == t1) begin
            t2 = (t1 % IPAD_N) + 1;
        end
        load_weights(t2);
        do_run(20);

        finish_run();
    end

endmodule

//--- pe.f
src/pe_cfg_pkg.sv
src/pe_ctl_pkg.sv
src/pe_op_if.sv
src/pe_pad_rf.sv
src/pe_dp_ctrl.sv
src/pe_mac.sv
src/pe_psum_out.sv
src/pe.sv
bench/pe_asserts.sv
bench/pe_tb.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the PE testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal \
        --top-module pe_tb -f pe.f -o pe_sim; then
    echo "build failed"
    exit 1
fi

output=$(./obj_dir/pe_sim)
status=$?
printf '%s\n' "$output"

if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "Everything OK"; then
    exit 0
fi
exit 1

//--- src/pe.sv
`timescale 1ns/1ns

module pe
    import pe_cfg_pkg::*;
    import pe_ctl_pkg::*;
(
    input  logic     i_clk,
    input  logic     i_rstn,
    input  pe_inst_e i_inst,
    input  logic     i_inst_valid,
    input  tap_cnt_t i_taps,
    input  logic     i_input_rdy,
    output logic     o_input_ack,
    input  data_t    i_input,
    input  logic     i_weight_rdy,
    output logic     o_weight_ack,
    input  data_t    i_weight [PE_ROW],
    output logic     o_psum_rdy,
    input  logic     i_psum_ack,
    output psum_t    o_psum [PE_ROW],
    output logic     o_idle
);

    logic      psum_free;
    logic      ipad_write;
    pad_addr_t ipad_waddr;
    logic      wpad_write;
    pad_addr_t wpad_tap;
    data_t     ipad_word;
    data_t     wpad_word [PE_ROW];
    logic      mac_done;
    psum_t     mac_psum [PE_ROW];

    pe_op_if op_if ();

    // ============================================================
    // decode
    // ============================================================

    pe_dp_ctrl u_ctrl (
        .i_clk        (i_clk),
        .i_rstn       (i_rstn),
        .i_inst       (i_inst),
        .i_inst_valid (i_inst_valid),
        .i_taps       (i_taps),
        .i_input_rdy  (i_input_rdy),
        .o_input_ack  (o_input_ack),
        .i_weight_rdy (i_weight_rdy),
        .o_weight_ack (o_weight_ack),
        .i_psum_free  (psum_free),
        .o_ipad_write (ipad_write),
        .o_ipad_waddr (ipad_waddr),
        .o_wpad_write (wpad_write),
        .o_wpad_tap   (wpad_tap),
        .o_idle       (o_idle),
        .op           (op_if)
    );

    // input window, circular
    pe_pad_rf #(.SIZE(IPAD_N)) u_ipad (
        .i_clk   (i_clk),
        .i_rstn  (i_rstn),
        .i_write (ipad_write),
        .i_waddr (ipad_waddr),
        .i_wdata (i_input),
        .i_raddr (op_if.ipad_addr),
        .o_rdata (ipad_word)
    );

    // weight pads, one per row, addressed by tap
    for (genvar r = 0; r < PE_ROW; r++) begin : g_wpad
        pe_pad_rf #(.SIZE(IPAD_N)) u_wpad (
            .i_clk   (i_clk),
            .i_rstn  (i_rstn),
            .i_write (wpad_write),
            .i_waddr (wpad_tap),
            .i_wdata (i_weight[r]),
            .i_raddr (op_if.wpad_tap),
            .o_rdata (wpad_word[r])
        );
    end

    // ============================================================
    // execute and result
    // ============================================================

    pe_mac u_mac (
        .i_clk       (i_clk),
        .i_rstn      (i_rstn),
        .op          (op_if),
        .i_ipad_word (ipad_word),
        .i_wpad_word (wpad_word),
        .o_done      (mac_done),
        .o_psum      (mac_psum)
    );

    pe_psum_out u_out (
        .i_clk      (i_clk),
        .i_rstn     (i_rstn),
        .i_done     (mac_done),
        .i_psum     (mac_psum),
        .o_free     (psum_free),
        .o_psum_rdy (o_psum_rdy),
        .i_psum_ack (i_psum_ack),
        .o_psum     (o_psum)
    );

endmodule

//--- src/pe_cfg_pkg.sv
package pe_cfg_pkg;

    // ============================================================
    // data widths
    // ============================================================

    // input and weight samples
    localparam int DWD      = 8;
    // enough for IPAD_N signed 8x8 products
    localparam int PSUM_DWD = 20;

    // ============================================================
    // array and pad sizes
    // ============================================================

    localparam int PE_ROW = 4;
    // window length, also the largest tap count
    localparam int IPAD_N = 4;
    localparam int PAD_AW = $clog2(IPAD_N);

    typedef logic signed [DWD-1:0]      data_t;
    typedef logic signed [PSUM_DWD-1:0] psum_t;
    typedef logic        [PAD_AW-1:0]   pad_addr_t;

endpackage

//--- src/pe_ctl_pkg.sv
package pe_ctl_pkg;

    // ============================================================
    // control encodings
    // ============================================================

    // tap count, 1 up to the window length
    localparam int TAP_W = 3;
    typedef logic [TAP_W-1:0] tap_cnt_t;

    // instruction word, sampled with the valid strobe
    typedef enum logic [1:0] {
        INST_NOP    = 2'd0,
        INST_LOAD_W = 2'd1,
        INST_RUN    = 2'd2,
        INST_STOP   = 2'd3
    } pe_inst_e;

    // data path controller states
    typedef enum logic [1:0] {
        ST_IDLE   = 2'd0,
        ST_LOAD_W = 2'd1,
        ST_RUN    = 2'd2,
        ST_ISSUE  = 2'd3
    } pe_state_e;

endpackage

//--- src/pe_dp_ctrl.sv
`timescale 1ns/1ns

module pe_dp_ctrl
    import pe_cfg_pkg::*;
    import pe_ctl_pkg::*;
(
    input  logic      i_clk,
    input  logic      i_rstn,
    input  pe_inst_e  i_inst,
    input  logic      i_inst_valid,
    input  tap_cnt_t  i_taps,
    input  logic      i_input_rdy,
    output logic      o_input_ack,
    input  logic      i_weight_rdy,
    output logic      o_weight_ack,
    input  logic      i_psum_free,
    output logic      o_ipad_write,
    output pad_addr_t o_ipad_waddr,
    output logic      o_wpad_write,
    output pad_addr_t o_wpad_tap,
    output logic      o_idle,
    pe_op_if.ctrl     op
);

    pe_state_e state;
    tap_cnt_t  taps_r;
    tap_cnt_t  wcnt;
    tap_cnt_t  fill_cnt;
    tap_cnt_t  icnt;
    pad_addr_t wptr;
    pad_addr_t issue_tap;
    logic      window_start;
    logic      wload_last;
    logic      issue_last;
    logic      stop_req;

    // ============================================================
    // channel handshakes
    // ============================================================

    // no input while a window issues or the output stage is busy
    assign o_input_ack  = (state == ST_RUN) && i_psum_free && i_input_rdy;
    assign o_weight_ack = (state == ST_LOAD_W) && i_weight_rdy;

    assign window_start = o_input_ack && (fill_cnt + tap_cnt_t'(1) >= taps_r);
    assign wload_last   = (wcnt == taps_r - tap_cnt_t'(1));
    assign issue_last   = (icnt == taps_r - tap_cnt_t'(1));
    assign stop_req     = i_inst_valid && (i_inst == INST_STOP);

    assign o_ipad_write = o_input_ack;
    assign o_ipad_waddr = wptr;
    assign o_wpad_write = o_weight_ack;
    assign o_wpad_tap   = pad_addr_t'(wcnt);
    assign o_idle       = (state == ST_IDLE);

    // tap k reads the sample from k inputs ago, newest sits at wptr-1
    assign issue_tap    = pad_addr_t'(icnt);
    assign op.op_valid  = (state == ST_ISSUE);
    assign op.ipad_addr = wptr - issue_tap - pad_addr_t'(1);
    assign op.wpad_tap  = issue_tap;
    assign op.op_first  = (icnt == '0);
    assign op.op_last   = issue_last;

    // ============================================================
    // controller FSM
    // ============================================================

    always_ff @(posedge i_clk or negedge i_rstn) begin
        if (!i_rstn) begin
            state    <= ST_IDLE;
            taps_r   <= '0;
            wcnt     <= '0;
            fill_cnt <= '0;
            icnt     <= '0;
            wptr     <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (i_inst_valid && i_inst == INST_LOAD_W) begin
                        taps_r <= i_taps;
                        wcnt   <= '0;
                        state  <= ST_LOAD_W;
                    end else if (i_inst_valid && i_inst == INST_RUN) begin
                        fill_cnt <= '0;
                        state    <= ST_RUN;
                    end
                end
                ST_LOAD_W: begin
                    if (o_weight_ack) begin
                        wcnt <= wcnt + tap_cnt_t'(1);
                        if (wload_last) begin
                            state <= ST_IDLE;
                        end
                    end
                end
                ST_RUN: begin
                    // fill count saturates once the window is full
                    if (o_input_ack) begin
                        wptr <= wptr + pad_addr_t'(1);
                        if (fill_cnt < taps_r) begin
                            fill_cnt <= fill_cnt + tap_cnt_t'(1);
                        end
                    end
                    if (window_start) begin
                        icnt  <= '0;
                        state <= ST_ISSUE;
                    end else if (stop_req) begin
                        state <= ST_IDLE;
                    end
                end
                ST_ISSUE: begin
                    icnt <= icnt + tap_cnt_t'(1);
                    if (issue_last) begin
                        state <= ST_RUN;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

endmodule

//--- src/pe_mac.sv
`timescale 1ns/1ns

module pe_mac
    import pe_cfg_pkg::*;
(
    input  logic  i_clk,
    input  logic  i_rstn,
    pe_op_if.mac  op,
    input  data_t i_ipad_word,
    input  data_t i_wpad_word [PE_ROW],
    output logic  o_done,
    output psum_t o_psum [PE_ROW]
);

    psum_t prod [PE_ROW];
    psum_t acc  [PE_ROW];
    logic  done_q;

    // ============================================================
    // per-row multiply and accumulate
    // ============================================================

    for (genvar r = 0; r < PE_ROW; r++) begin : g_row
        // shared input word times this row's weight, sign extended
        assign prod[r] = i_ipad_word * i_wpad_word[r];

        always_ff @(posedge i_clk) begin
            if (op.op_valid) begin
                if (op.op_first) begin
                    acc[r] <= prod[r];
                end else begin
                    acc[r] <= acc[r] + prod[r];
                end
            end
        end

        assign o_psum[r] = acc[r];
    end

    // result is in acc the cycle after the last tap
    always_ff @(posedge i_clk or negedge i_rstn) begin
        if (!i_rstn) begin
            done_q <= 1'b0;
        end else begin
            done_q <= op.op_valid && op.op_last;
        end
    end

    assign o_done = done_q;

endmodule

//--- src/pe_op_if.sv
`timescale 1ns/1ns

// one tap operation from the controller to the MAC stage
interface pe_op_if
    import pe_cfg_pkg::*;
();
    logic      op_valid;
    // slot of the input window used by this tap
    pad_addr_t ipad_addr;
    // tap index into every row's weight pad
    pad_addr_t wpad_tap;
    // first and last tap of one window
    logic      op_first;
    logic      op_last;

    modport ctrl (
        output op_valid, ipad_addr, wpad_tap, op_first, op_last
    );

    modport mac (
        input op_valid, ipad_addr, wpad_tap, op_first, op_last
    );

endinterface

//--- src/pe_pad_rf.sv
`timescale 1ns/1ns

// small scratchpad, sync write and comb read
module pe_pad_rf
    import pe_cfg_pkg::*;
#(
    parameter int SIZE = IPAD_N
) (
    input  logic      i_clk,
    input  logic      i_rstn,
    input  logic      i_write,
    input  pad_addr_t i_waddr,
    input  data_t     i_wdata,
    input  pad_addr_t i_raddr,
    output data_t     o_rdata
);

    data_t mem [SIZE];

    always_ff @(posedge i_clk or negedge i_rstn) begin
        if (!i_rstn) begin
            for (int i = 0; i < SIZE; i++) begin
                mem[i] <= '0;
            end
        end else if (i_write) begin
            mem[i_waddr] <= i_wdata;
        end
    end

    // read is visible in the same cycle as the address
    assign o_rdata = mem[i_raddr];

endmodule

//--- src/pe_psum_out.sv
`timescale 1ns/1ns

// one-entry psum buffer on the rdy/ack output channel
module pe_psum_out
    import pe_cfg_pkg::*;
(
    input  logic  i_clk,
    input  logic  i_rstn,
    input  logic  i_done,
    input  psum_t i_psum [PE_ROW],
    output logic  o_free,
    output logic  o_psum_rdy,
    input  logic  i_psum_ack,
    output psum_t o_psum [PE_ROW]
);

    logic  full_q;
    psum_t psum_q [PE_ROW];

    always_ff @(posedge i_clk or negedge i_rstn) begin
        if (!i_rstn) begin
            full_q <= 1'b0;
        end else if (i_done) begin
            full_q <= 1'b1;
        end else if (full_q && i_psum_ack) begin
            full_q <= 1'b0;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_done) begin
            psum_q <= i_psum;
        end
    end

    assign o_psum_rdy = full_q;
    assign o_psum     = psum_q;
    // a pending done counts as occupied, so a new window never overwrites
    assign o_free     = !full_q && !i_done;

endmodule
